/* rtl/bank_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Storage for both banks, one write port and one read port
// Read data is registered on every edge, one cycle of latency
// Contents are undefined after reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module bank_ram (
  input  logic                 write_clock,
  input  logic                 ram_write_enable,
  input  fifo_pkg::bank_addr_u ram_write_address,
  input  fifo_pkg::data_t      ram_write_data,
  input  fifo_pkg::bank_addr_u ram_read_address,
  output fifo_pkg::data_t      ram_read_data
);
  import fifo_pkg::*;

  // Bank 0 in the lower half, bank 1 in the upper half
  data_t mem [NUM_BANKS * BANK_DEPTH];

  // Write port, only on enabled edges
  always_ff @(posedge write_clock) begin
    if (ram_write_enable) begin
      mem[ram_write_address.flat] <= ram_write_data;
    end
  end

  // Read port, address is already the look-ahead one
  always_ff @(posedge write_clock) begin
    ram_read_data <= mem[ram_read_address.flat];
  end

endmodule

/* rtl/fifo_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and types shared by the ping-pong block FIFO
// Two banks only, the controllers rely on a one-bit bank select
// Counts run 0 to BANK_DEPTH, so they are one bit wider than an offset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fifo_pkg;

  // Word and bank geometry
  localparam int DATA_WIDTH    = 8;
  localparam int ADDRESS_WIDTH = 4;
  localparam int BANK_DEPTH    = 1 << ADDRESS_WIDTH;
  localparam int NUM_BANKS     = 2;

  // Extra bit so a completely full bank fits
  localparam int COUNT_WIDTH   = ADDRESS_WIDTH + 1;

  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [ADDRESS_WIDTH-1:0] offset_t;
  typedef logic [COUNT_WIDTH-1:0]   count_t;

  // RAM address seen two ways
  // flat is the storage index, field is bank select above the word offset
  typedef union packed {
    logic [ADDRESS_WIDTH:0] flat;
    struct packed {
      logic    bank;
      offset_t offset;
    } field;
  } bank_addr_u;

endpackage

/* rtl/ping_pong_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ping-pong block FIFO, single clock
// Two banks of BANK_DEPTH words, one held by each side at most
// read_data lags the claim or strobe edge by one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ping_pong_fifo (
  input  logic             write_clock,
  input  logic             reset,
  input  logic             write_activate,
  input  logic             write_strobe,
  input  fifo_pkg::data_t  write_data,
  output logic             write_ready,
  input  logic             read_activate,
  input  logic             read_strobe,
  output logic             read_ready,
  output fifo_pkg::count_t read_count,
  output fifo_pkg::data_t  read_data,
  output logic             inactive
);
  import fifo_pkg::*;

  // Writer to storage
  logic       ram_write_enable;
  bank_addr_u ram_write_address;
  data_t      ram_write_data;
  // Reader to storage
  bank_addr_u ram_read_address;
  // Bank handover in both directions
  logic       bank_filled;
  logic       filled_bank;
  count_t     filled_count;
  logic       bank_released;
  logic       released_bank;

  write_bank_ctrl write_ctrl_i (
    .write_clock       (write_clock),
    .reset             (reset),
    .write_activate    (write_activate),
    .write_strobe      (write_strobe),
    .write_data        (write_data),
    .bank_released     (bank_released),
    .released_bank     (released_bank),
    .write_ready       (write_ready),
    .inactive          (inactive),
    .ram_write_enable  (ram_write_enable),
    .ram_write_address (ram_write_address),
    .ram_write_data    (ram_write_data),
    .bank_filled       (bank_filled),
    .filled_bank       (filled_bank),
    .filled_count      (filled_count)
  );

  read_bank_ctrl read_ctrl_i (
    .write_clock      (write_clock),
    .reset            (reset),
    .read_activate    (read_activate),
    .read_strobe      (read_strobe),
    .bank_filled      (bank_filled),
    .filled_bank      (filled_bank),
    .filled_count     (filled_count),
    .read_ready       (read_ready),
    .read_count       (read_count),
    .ram_read_address (ram_read_address),
    .bank_released    (bank_released),
    .released_bank    (released_bank)
  );

  // Registered RAM output is the FIFO read data
  bank_ram ram_i (
    .write_clock       (write_clock),
    .ram_write_enable  (ram_write_enable),
    .ram_write_address (ram_write_address),
    .ram_write_data    (ram_write_data),
    .ram_read_address  (ram_read_address),
    .ram_read_data     (read_data)
  );

endmodule

/* rtl/read_bank_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reader side of the ping-pong FIFO
// Full banks are served in the order they were filled
// read_count is zero while read_ready is low
// Strobes past the last word of a block are dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module read_bank_ctrl (
  input  logic                 write_clock,
  input  logic                 reset,
  input  logic                 read_activate,
  input  logic                 read_strobe,
  input  logic                 bank_filled,
  input  logic                 filled_bank,
  input  fifo_pkg::count_t     filled_count,
  output logic                 read_ready,
  output fifo_pkg::count_t     read_count,
  output fifo_pkg::bank_addr_u ram_read_address,
  output logic                 bank_released,
  output logic                 released_bank
);
  import fifo_pkg::*;

  logic [NUM_BANKS-1:0] bank_full;
  count_t               saved_count [NUM_BANKS];
  // Bank to serve next, valid whenever its full flag is set
  logic                 oldest;
  logic                 reading;
  logic                 read_bank;
  // Offset of the word currently on read_data
  offset_t              read_offset;
  offset_t              offset_next;
  logic                 claim;
  logic                 release_now;
  logic                 strobe_accept;

  assign read_ready = !reading && bank_full[oldest];
  assign read_count = read_ready ? saved_count[oldest] : '0;

  always_comb begin
    claim         = read_activate && read_ready;
    release_now   = reading && !read_activate;
    // Advance only while another word remains in the block
    strobe_accept = reading && read_strobe &&
                    ((count_t'(read_offset) + count_t'(1)) < saved_count[read_bank]);
    offset_next   = read_offset + offset_t'(strobe_accept);
  end

  // Look-ahead address
  // Idle points at word 0 of the oldest bank so data is ready at claim
  always_comb begin
    ram_read_address.field.bank   = reading ? read_bank : oldest;
    ram_read_address.field.offset = offset_next;
  end

  always_ff @(posedge write_clock) begin
    if (reset) begin
      bank_full     <= '0;
      oldest        <= 1'b0;
      reading       <= 1'b0;
      read_bank     <= 1'b0;
      read_offset   <= '0;
      bank_released <= 1'b0;
    end else begin
      bank_released <= release_now;

      // New block from the writer
      // It is oldest unless the other bank is still waiting
      if (bank_filled) begin
        bank_full[filled_bank] <= 1'b1;
        if (!bank_full[~filled_bank]) begin
          oldest <= filled_bank;
        end
      end

      // Reader takes the oldest bank, the other one is next in line
      if (claim) begin
        bank_full[oldest] <= 1'b0;
        oldest            <= ~oldest;
        reading           <= 1'b1;
        read_bank         <= oldest;
      end

      if (release_now) begin
        reading     <= 1'b0;
        read_offset <= '0;
      end else begin
        read_offset <= offset_next;
      end
    end
  end

  // Block sizes and release target, qualified by the flags above
  always_ff @(posedge write_clock) begin
    if (bank_filled) begin
      saved_count[filled_bank] <= filled_count;
    end
    if (release_now) begin
      released_bank <= read_bank;
    end
  end

endmodule

/* rtl/write_bank_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writer side of the ping-pong FIFO
// write_ready is registered, low in reset and in the first cycle after it
// Strobes past BANK_DEPTH words or with no bank held are dropped
// An empty block is never handed to the reader
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module write_bank_ctrl (
  input  logic                 write_clock,
  input  logic                 reset,
  input  logic                 write_activate,
  input  logic                 write_strobe,
  input  fifo_pkg::data_t      write_data,
  input  logic                 bank_released,
  input  logic                 released_bank,
  output logic                 write_ready,
  output logic                 inactive,
  output logic                 ram_write_enable,
  output fifo_pkg::bank_addr_u ram_write_address,
  output fifo_pkg::data_t      ram_write_data,
  output logic                 bank_filled,
  output logic                 filled_bank,
  output fifo_pkg::count_t     filled_count
);
  import fifo_pkg::*;

  logic [NUM_BANKS-1:0] bank_free;
  logic [NUM_BANKS-1:0] free_next;
  logic                 holding;
  logic                 holding_next;
  logic                 held_bank;
  logic                 claim_bank;
  count_t               write_count;
  count_t               count_next;
  logic                 claim;
  logic                 release_now;
  logic                 write_accept;

  // Lowest numbered free bank wins
  assign claim_bank = bank_free[0] ? 1'b0 : 1'b1;

  always_comb begin
    claim        = write_activate && write_ready;
    release_now  = holding && !write_activate;
    // Cap at one full bank
    write_accept = holding && write_strobe && (write_count < count_t'(BANK_DEPTH));
    count_next   = write_count + count_t'(write_accept);

    free_next = bank_free;
    // Reader hands back a bank it finished with
    if (bank_released) begin
      free_next[released_bank] = 1'b1;
    end
    if (claim) begin
      free_next[claim_bank] = 1'b0;
    end
    // Nothing written, so the bank goes straight back to the pool
    if (release_now && (count_next == '0)) begin
      free_next[held_bank] = 1'b1;
    end

    holding_next = (holding && write_activate) || claim;
  end

  // RAM write port, offset is the running count
  always_comb begin
    ram_write_enable               = write_accept;
    ram_write_address.field.bank   = held_bank;
    ram_write_address.field.offset = write_count[ADDRESS_WIDTH-1:0];
    ram_write_data                 = write_data;
  end

  always_ff @(posedge write_clock) begin
    if (reset) begin
      bank_free   <= '1;
      holding     <= 1'b0;
      held_bank   <= 1'b0;
      write_count <= '0;
      write_ready <= 1'b0;
      bank_filled <= 1'b0;
    end else begin
      bank_free   <= free_next;
      holding     <= holding_next;
      write_ready <= !holding_next && (|free_next);
      // One-cycle handover pulse, only for blocks with data
      bank_filled <= release_now && (count_next != '0);
      if (claim) begin
        held_bank <= claim_bank;
      end
      if (release_now) begin
        write_count <= '0;
      end else begin
        write_count <= count_next;
      end
    end
  end

  // Handover payload, qualified by bank_filled
  always_ff @(posedge write_clock) begin
    if (release_now) begin
      filled_bank  <= held_bank;
      filled_count <= count_next;
    end
  end

  // Idle when nothing is held anywhere
  assign inactive = (&bank_free) && !holding;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
verilator --binary --timing -sv -f sources.f --top-module ping_pong_fifo_tb -Mdir obj_dir -o sim \
  && ./obj_dir/sim | tee /dev/stderr | grep -qx "ALL TESTS PASSED" \
  && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }

/* sources.f */
+incdir+verification
rtl/fifo_pkg.sv
rtl/bank_ram.sv
rtl/write_bank_ctrl.sv
rtl/read_bank_ctrl.sv
rtl/ping_pong_fifo.sv
verification/tb_clock_gen.sv
verification/ping_pong_fifo_tb.sv

/* verification/tb_checks.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compare tasks and error counters for the FIFO testbench
// Included inside a module that already imports fifo_pkg
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count  = 0;
int tests_run    = 0;
int tests_failed = 0;

task automatic compare_data(input string name, input data_t actual, input data_t expected);
  if (actual !== expected) begin
    $display("Mismatch at %0t: %s is 0x%02h, expected 0x%02h", $time, name, actual, expected);
    error_count++;
  end
endtask

task automatic compare_count(input string name, input count_t actual, input count_t expected);
  if (actual !== expected) begin
    $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
    error_count++;
  end
endtask

task automatic compare_flag(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
    error_count++;
  end
endtask

// One line per finished test
task automatic finish_test(input string name, input int errors_before);
  tests_run++;
  if (error_count != errors_before) begin
    tests_failed++;
    $display("Test %s: failed with %0d errors", name, error_count - errors_before);
  end else begin
    $display("Test %s: ok", name);
  end
endtask

`endif

/* verification/ping_pong_fifo_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for the ping-pong block FIFO
// Inputs change 1 ns after each rising edge, outputs are sampled there
// Expected data is a queue filled as words are written
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ping_pong_fifo_tb;
  import fifo_pkg::*;
  `include "tb_checks.svh"

  localparam int WAIT_LIMIT = 64;

  logic   write_clock;
  logic   reset;
  logic   write_activate;
  logic   write_strobe;
  data_t  write_data;
  logic   write_ready;
  logic   read_activate;
  logic   read_strobe;
  logic   read_ready;
  count_t read_count;
  data_t  read_data;
  logic   inactive;
  int     seed = 76999;
  data_t  expected [$];

  tb_clock_gen clock_gen_i (.write_clock(write_clock), .reset(reset));

  ping_pong_fifo dut_i (.*);

  task automatic next_cycle();
    @(posedge write_clock);
    #1;
  endtask

  // Selects the level a wait loop is after
  function automatic logic level_of(input int which);
    case (which)
      0: return write_ready;
      1: return read_ready;
      2: return write_ready && inactive;
      default: return !reset;
    endcase
  endfunction

  task automatic wait_for(input int which, input string what);
    int cycles;
    cycles = 0;
    while (!level_of(which) && cycles < WAIT_LIMIT) begin
      next_cycle();
      cycles++;
    end
    if (!level_of(which)) begin
      $display("Timed out at %0t waiting for %s", $time, what);
      error_count++;
    end
  endtask

  // Claim, strobe n words, release; words past one bank are not expected back
  task automatic write_block(input int n);
    wait_for(0, "write_ready");
    write_activate = 1'b1;
    next_cycle();
    for (int i = 0; i < n; i++) begin
      write_data   = data_t'($random(seed));
      write_strobe = 1'b1;
      if (i < BANK_DEPTH) expected.push_back(write_data);
      next_cycle();
    end
    write_strobe   = 1'b0;
    write_activate = 1'b0;
    next_cycle();
  endtask

  // Word 0 appears after the claim edge, each strobe edge brings the next
  task automatic read_block(input int n);
    wait_for(1, "read_ready");
    compare_count("read_count", read_count, count_t'(n));
    read_activate = 1'b1;
    next_cycle();
    for (int i = 0; i < n; i++) begin
      if (expected.size() == 0) begin
        $display("Expected data ran out at %0t", $time);
        error_count++;
      end else begin
        compare_data("read_data", read_data, expected.pop_front());
      end
      read_strobe = (i < n - 1);
      if (i < n - 1) next_cycle();
    end
    read_strobe   = 1'b0;
    read_activate = 1'b0;
    next_cycle();
  endtask

  initial begin
    int errs;
    write_activate = 1'b0;
    write_strobe   = 1'b0;
    write_data     = '0;
    read_activate  = 1'b0;
    read_strobe    = 1'b0;

    errs = error_count;
    // First edge is always inside reset
    next_cycle();
    wait_for(3, "reset release");
    next_cycle();
    compare_flag("write_ready", write_ready, 1'b1);
    compare_flag("read_ready", read_ready, 1'b0);
    compare_flag("inactive", inactive, 1'b1);
    finish_test("reset state", errs);

    errs = error_count;
    write_block(5);
    read_block(5);
    wait_for(2, "write_ready and inactive");
    finish_test("single block", errs);

    errs = error_count;
    write_block(7);
    // Second bank is still free
    compare_flag("write_ready", write_ready, 1'b1);
    write_block(3);
    repeat (5) begin
      compare_flag("write_ready", write_ready, 1'b0);
      next_cycle();
    end
    read_block(7);
    read_block(3);
    wait_for(2, "write_ready and inactive");
    finish_test("ping-pong order", errs);

    errs = error_count;
    write_block(20);
    read_block(BANK_DEPTH);
    wait_for(2, "write_ready and inactive");
    finish_test("full bank", errs);

    errs = error_count;
    write_block(0);
    repeat (10) begin
      compare_flag("read_ready", read_ready, 1'b0);
      compare_flag("write_ready", write_ready, 1'b1);
      compare_flag("inactive", inactive, 1'b1);
      next_cycle();
    end
    finish_test("empty release", errs);

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verification/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running 4 ns clock, reset high over the first three edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clock_gen (
  output logic write_clock,
  output logic reset
);

  initial begin
    write_clock = 1'b0;
    forever #2 write_clock = ~write_clock;
  end

  // Released like a flop output so the DUT sees a clean third reset edge
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge write_clock);
    reset <= 1'b0;
  end

endmodule
